//--- include/wb_consts.svh
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// Width of the integer data path and of every register file entry
`define WB_XLEN 32

// Number of integer registers, x0 included
`define WB_NUM_REGS 32

// Register index width, enough to address all of the registers above
`define WB_RADDR_W 5

`endif

//--- logic/wb_pkg.sv
`include "wb_consts.svh"

package wb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Basic types

  // Register index as carried through the pipe and into the register file
  typedef logic [`WB_RADDR_W-1:0] rf_addr_t;

  // Memory protection result reported by the LSU with each response
  typedef enum logic [1:0] {
    MPU_OK       = 2'h0,
    MPU_RE_FAULT = 2'h1,
    MPU_WR_FAULT = 2'h2
  } mpu_status_e;

  // Alignment check result reported by the LSU with each response
  typedef enum logic {
    ALIGN_OK     = 1'b0,
    ALIGN_WR_ERR = 1'b1
  } align_status_e;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline and controller structs

  // Everything the write-back stage needs to know about one instruction
  typedef struct packed {
    logic                instr_valid;
    logic                rf_we;
    rf_addr_t            rf_waddr;
    logic [`WB_XLEN-1:0] rf_wdata;
    // Result comes from the LSU
    logic                lsu_en;
    // Result comes from the coprocessor
    logic                xif_en;
    // Earlier stages already decided to terminate the sequence
    logic                abort_op;
    // Final operation of a possibly multi-part instruction
    logic                last_op;
  } ex_wb_pipe_t;

  // Controller requests towards WB, driven from outside in this subsystem
  typedef struct packed {
    logic halt_wb;
    // Halt used only around sleep, kept separate for timing reasons
    logic halt_limited_wb;
    logic kill_wb;
  } ctrl_fsm_t;

endpackage

//--- logic/ex_wb_if.sv
`timescale 1ns/100ps

// Bundle between the EX/WB pipe register and the write-back stage
interface ex_wb_if;

  // Instruction currently held in the pipe register
  wb_pkg::ex_wb_pipe_t ex_wb_pipe;

  // WB can take the held instruction off the pipe at the next edge
  logic                wb_ready;

  // Halt and kill requests, read by both ends
  wb_pkg::ctrl_fsm_t   ctrl_fsm;

  // Pipe register side, owns the instruction
  modport pipe (
    output ex_wb_pipe,
    input  wb_ready
  );

  // Write-back side, owns the ready
  modport wb (
    input  ex_wb_pipe,
    output wb_ready
  );

  // Controller requests, read only
  modport ctrl (
    input  ctrl_fsm
  );

endinterface

//--- logic/xif_result_if.sv
`timescale 1ns/100ps

`include "wb_consts.svh"

// Result channel of the coprocessor extension interface
interface xif_result_if;

  logic                result_valid;
  logic                result_ready;
  logic [`WB_XLEN-1:0] result_data;
  // Synchronous exception raised by the coprocessor for this result
  logic                result_exc;

  // Core side, accepts results
  modport cpu (
    input  result_valid,
    output result_ready,
    input  result_data,
    input  result_exc
  );

  // Coprocessor side, offers results
  modport copro (
    output result_valid,
    input  result_ready,
    output result_data,
    output result_exc
  );

endinterface

//--- logic/ex_wb_pipe_reg.sv
`timescale 1ns/100ps

module ex_wb_pipe_reg (
  input  logic                clk,
  input  logic                rst_n,

  // Instruction offered by the EX side
  input  logic                ex_valid_i,
  output logic                ex_ready_o,
  input  wb_pkg::ex_wb_pipe_t ex_pipe_i,

  // Towards the write-back stage
  ex_wb_if.pipe               pipe_if,
  ex_wb_if.ctrl               ctrl_if
);

  // Goes high in the first cycle after reset and stays there
  logic                out_of_reset_q;
  // Occupancy of the single entry
  logic                valid_q;
  // Instruction fields, loaded only when a new instruction is taken
  wb_pkg::ex_wb_pipe_t payload_q;
  logic                accept;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake with EX

  // Room is available when the entry is empty or is leaving this cycle
  assign ex_ready_o = out_of_reset_q && (!valid_q || pipe_if.wb_ready);

  // A transfer happens on an edge where both sides agree
  assign accept = ex_valid_i && ex_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Control flops

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_of_reset_q <= 1'b0;
      valid_q        <= 1'b0;
    end else begin
      out_of_reset_q <= 1'b1;
      if (accept) begin
        // New instruction replaces whatever leaves WB this cycle
        valid_q <= 1'b1;
      end else if (pipe_if.wb_ready || ctrl_if.ctrl_fsm.kill_wb) begin
        // Retired or killed entry with nothing behind it
        valid_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload

  always_ff @(posedge clk) begin
    if (accept) begin
      payload_q <= ex_pipe_i;
    end
  end

  // The occupancy flop is the only trusted valid; the stored copy is ignored
  always_comb begin
    pipe_if.ex_wb_pipe             = payload_q;
    pipe_if.ex_wb_pipe.instr_valid = valid_q;
  end

endmodule

//--- logic/wb_stage.sv
`timescale 1ns/100ps

`include "wb_consts.svh"

module wb_stage (
  input  logic                  clk,
  input  logic                  rst_n,

  // Pipe contents and controller requests
  ex_wb_if.wb                   wb_if,
  ex_wb_if.ctrl                 ctrl_if,

  // LSU response, status is only meaningful while lsu_rvalid_i is high
  input  logic [`WB_XLEN-1:0]   lsu_rdata_i,
  input  logic                  lsu_rvalid_i,
  input  wb_pkg::mpu_status_e   lsu_mpu_status_i,
  input  wb_pkg::align_status_e lsu_align_status_i,
  input  logic                  lsu_wpt_match_i,
  input  logic                  lsu_ready_i,
  output logic                  lsu_valid_o,

  // Coprocessor result channel
  xif_result_if.cpu             xif_if,

  // Register file write port
  output logic                  rf_we_o,
  output wb_pkg::rf_addr_t      rf_waddr_o,
  output logic [`WB_XLEN-1:0]   rf_wdata_o,

  // Retirement and status
  output logic                  wb_valid_o,
  output logic                  data_stall_o,
  output logic                  last_op_o,
  output logic                  abort_op_o,
  output wb_pkg::mpu_status_e   mpu_status_wb_o,
  output wb_pkg::align_status_e align_status_wb_o,
  output logic                  wpt_match_wb_o
);

  wb_pkg::ex_wb_pipe_t   pipe;
  wb_pkg::ctrl_fsm_t     ctrl;

  // Instruction present and neither halted nor killed
  logic                  halted;
  logic                  instr_valid;
  logic                  wb_valid;

  // Coprocessor tracking
  logic                  xif_instr;
  logic                  xif_waiting;
  logic                  xif_exception;

  // LSU tracking
  logic                  lsu_waiting;
  logic                  lsu_fault;
  logic                  lsu_wpt_hit;

  // Sticky copies of the one-cycle LSU response
  logic                  lsu_valid_q;
  logic                  lsu_wpt_match_q;
  wb_pkg::mpu_status_e   lsu_mpu_status_q;
  wb_pkg::align_status_e lsu_align_status_q;

  // Response as seen by WB, either live or held
  logic                  lsu_valid;
  logic                  lsu_wpt_match;
  wb_pkg::mpu_status_e   lsu_mpu_status;
  wb_pkg::align_status_e lsu_align_status;

  assign pipe = wb_if.ex_wb_pipe;
  assign ctrl = ctrl_if.ctrl_fsm;

  // Either halt source stops retirement
  assign halted      = ctrl.halt_wb || ctrl.halt_limited_wb;
  assign instr_valid = pipe.instr_valid && !ctrl.kill_wb && !halted;

  ////////////////////////////////////////////////////////////////////////////
  // Sticky LSU status

  // A response may land while WB is halted; keep its status until retirement
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_valid_q        <= 1'b0;
      lsu_wpt_match_q    <= 1'b0;
      lsu_mpu_status_q   <= wb_pkg::MPU_OK;
      lsu_align_status_q <= wb_pkg::ALIGN_OK;
    end else if (wb_valid || ctrl.kill_wb) begin
      // Instruction is done or dropped, forget its response
      lsu_valid_q        <= 1'b0;
      lsu_wpt_match_q    <= 1'b0;
      lsu_mpu_status_q   <= wb_pkg::MPU_OK;
      lsu_align_status_q <= wb_pkg::ALIGN_OK;
    end else if (lsu_rvalid_i) begin
      lsu_valid_q        <= 1'b1;
      lsu_wpt_match_q    <= lsu_wpt_match_i;
      lsu_mpu_status_q   <= lsu_mpu_status_i;
      lsu_align_status_q <= lsu_align_status_i;
    end
  end

  // Held values win over the live inputs once captured
  assign lsu_valid        = lsu_valid_q ? 1'b1               : lsu_rvalid_i;
  assign lsu_wpt_match    = lsu_valid_q ? lsu_wpt_match_q    : lsu_wpt_match_i;
  assign lsu_mpu_status   = lsu_valid_q ? lsu_mpu_status_q   : lsu_mpu_status_i;
  assign lsu_align_status = lsu_valid_q ? lsu_align_status_q : lsu_align_status_i;

  // Status only counts when a response is actually there
  assign lsu_fault   = lsu_valid && ((lsu_mpu_status != wb_pkg::MPU_OK) ||
                                     (lsu_align_status != wb_pkg::ALIGN_OK));
  assign lsu_wpt_hit = lsu_valid && lsu_wpt_match;

  // Load or store in WB still waiting for its response
  assign lsu_waiting = pipe.instr_valid && pipe.lsu_en && !lsu_valid;

  assign mpu_status_wb_o   = lsu_mpu_status;
  assign align_status_wb_o = lsu_align_status;
  assign wpt_match_wb_o    = lsu_wpt_match;

  ////////////////////////////////////////////////////////////////////////////
  // Coprocessor result

  assign xif_instr     = pipe.instr_valid && pipe.xif_en;
  assign xif_waiting   = xif_instr && !xif_if.result_valid;
  assign xif_exception = xif_instr && xif_if.result_valid && xif_if.result_exc;

  // Results are taken in order, so WB is ready whenever it holds one
  assign xif_if.result_ready = xif_instr;

  ////////////////////////////////////////////////////////////////////////////
  // Retirement

  // LSU instructions finish with their response, others unless a result is missing
  assign wb_valid = ((!pipe.lsu_en && !xif_waiting) ||
                     ( pipe.lsu_en && lsu_valid)) && instr_valid;

  assign wb_valid_o = wb_valid;

  // Kill always frees the stage, otherwise every pending source must be done
  assign wb_if.wb_ready = ctrl.kill_wb ||
                          (lsu_ready_i && !lsu_waiting && !xif_waiting && !halted);

  assign lsu_valid_o  = pipe.instr_valid && pipe.lsu_en;
  assign data_stall_o = pipe.lsu_en && !lsu_valid && instr_valid;
  assign last_op_o    = pipe.last_op;

  // LSU faults and watchpoints end the sequence just like an earlier abort
  assign abort_op_o = pipe.instr_valid &&
                      (pipe.abort_op || (pipe.lsu_en && (lsu_fault || lsu_wpt_hit)));

  ////////////////////////////////////////////////////////////////////////////
  // Register file write

  // Only a retiring instruction writes; faults and exceptions block it
  assign rf_we_o = pipe.rf_we && wb_valid &&
                   !(pipe.lsu_en && (lsu_fault || lsu_wpt_hit)) &&
                   !xif_exception;

  assign rf_waddr_o = pipe.rf_waddr;

  // Load data is taken live; a good load never waits behind a halt
  assign rf_wdata_o = pipe.lsu_en ? lsu_rdata_i :
                      pipe.xif_en ? xif_if.result_data :
                      pipe.rf_wdata;

endmodule

//--- logic/wb_regfile.sv
`timescale 1ns/100ps

`include "wb_consts.svh"

module wb_regfile (
  input  logic                clk,
  input  logic                rst_n,

  // Write port from the write-back stage
  input  logic                we_i,
  input  wb_pkg::rf_addr_t    waddr_i,
  input  logic [`WB_XLEN-1:0] wdata_i,

  // Observation read port
  input  wb_pkg::rf_addr_t    raddr_i,
  output logic [`WB_XLEN-1:0] rdata_o
);

  logic [`WB_XLEN-1:0] regs [`WB_NUM_REGS];

  ////////////////////////////////////////////////////////////////////////////
  // Storage

  // All entries start at zero; x0 is never written afterwards
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `WB_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Writes become visible here from the cycle after the write edge
  assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

//--- logic/wb_subsys.sv
`timescale 1ns/100ps

`include "wb_consts.svh"

module wb_subsys (
  input  logic                  clk,
  input  logic                  rst_n,

  // Instruction entry from EX
  input  logic                  ex_valid_i,
  output logic                  ex_ready_o,
  input  logic                  ex_rf_we_i,
  input  wb_pkg::rf_addr_t      ex_rf_waddr_i,
  input  logic [`WB_XLEN-1:0]   ex_rf_wdata_i,
  input  logic                  ex_lsu_en_i,
  input  logic                  ex_xif_en_i,
  input  logic                  ex_abort_op_i,
  input  logic                  ex_last_op_i,

  // Controller requests
  input  logic                  halt_wb_i,
  input  logic                  halt_limited_wb_i,
  input  logic                  kill_wb_i,

  // LSU
  input  logic [`WB_XLEN-1:0]   lsu_rdata_i,
  input  logic                  lsu_rvalid_i,
  input  wb_pkg::mpu_status_e   lsu_mpu_status_i,
  input  wb_pkg::align_status_e lsu_align_status_i,
  input  logic                  lsu_wpt_match_i,
  input  logic                  lsu_ready_i,
  output logic                  lsu_valid_o,

  // Coprocessor result
  input  logic                  xif_result_valid_i,
  input  logic [`WB_XLEN-1:0]   xif_result_data_i,
  input  logic                  xif_result_exc_i,
  output logic                  xif_result_ready_o,

  // Register observation
  input  wb_pkg::rf_addr_t      rf_raddr_i,
  output logic [`WB_XLEN-1:0]   rf_rdata_o,

  // Retirement and status
  output logic                  wb_valid_o,
  output logic                  data_stall_o,
  output logic                  last_op_o,
  output logic                  abort_op_o,
  output wb_pkg::mpu_status_e   mpu_status_wb_o,
  output wb_pkg::align_status_e align_status_wb_o,
  output logic                  wpt_match_wb_o
);

  wb_pkg::ex_wb_pipe_t ex_pipe;

  // Write port between WB and the register file
  logic                rf_we;
  wb_pkg::rf_addr_t    rf_waddr;
  logic [`WB_XLEN-1:0] rf_wdata;

  ex_wb_if      ex_wb_bus ();
  xif_result_if xif_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // Port packing

  assign ex_pipe = '{
    instr_valid: ex_valid_i,
    rf_we:       ex_rf_we_i,
    rf_waddr:    ex_rf_waddr_i,
    rf_wdata:    ex_rf_wdata_i,
    lsu_en:      ex_lsu_en_i,
    xif_en:      ex_xif_en_i,
    abort_op:    ex_abort_op_i,
    last_op:     ex_last_op_i
  };

  assign ex_wb_bus.ctrl_fsm = '{
    halt_wb:         halt_wb_i,
    halt_limited_wb: halt_limited_wb_i,
    kill_wb:         kill_wb_i
  };

  // Coprocessor side of the result channel comes straight from the pins
  assign xif_bus.result_valid = xif_result_valid_i;
  assign xif_bus.result_data  = xif_result_data_i;
  assign xif_bus.result_exc   = xif_result_exc_i;
  assign xif_result_ready_o   = xif_bus.result_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Instances

  ex_wb_pipe_reg u_ex_wb_pipe_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_valid_i (ex_valid_i),
    .ex_ready_o (ex_ready_o),
    .ex_pipe_i  (ex_pipe),
    .pipe_if    (ex_wb_bus.pipe),
    .ctrl_if    (ex_wb_bus.ctrl)
  );

  wb_stage u_wb_stage (
    .clk                (clk),
    .rst_n              (rst_n),
    .wb_if              (ex_wb_bus.wb),
    .ctrl_if            (ex_wb_bus.ctrl),
    .lsu_rdata_i        (lsu_rdata_i),
    .lsu_rvalid_i       (lsu_rvalid_i),
    .lsu_mpu_status_i   (lsu_mpu_status_i),
    .lsu_align_status_i (lsu_align_status_i),
    .lsu_wpt_match_i    (lsu_wpt_match_i),
    .lsu_ready_i        (lsu_ready_i),
    .lsu_valid_o        (lsu_valid_o),
    .xif_if             (xif_bus.cpu),
    .rf_we_o            (rf_we),
    .rf_waddr_o         (rf_waddr),
    .rf_wdata_o         (rf_wdata),
    .wb_valid_o         (wb_valid_o),
    .data_stall_o       (data_stall_o),
    .last_op_o          (last_op_o),
    .abort_op_o         (abort_op_o),
    .mpu_status_wb_o    (mpu_status_wb_o),
    .align_status_wb_o  (align_status_wb_o),
    .wpt_match_wb_o     (wpt_match_wb_o)
  );

  wb_regfile u_wb_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

endmodule

//--- test/tb_wb_subsys.sv
`timescale 1ns/100ps

`include "wb_consts.svh"

module tb_wb_subsys;

  localparam int CLK_PERIOD       = 100;
  localparam int RESET_CYCLES     = 5;
  localparam int NUM_INSTR        = 300;
  localparam int CYCLES_PER_INSTR = 20;

  // Instruction kinds offered to the pipe
  localparam int KIND_ALU  = 0;
  localparam int KIND_LOAD = 1;
  localparam int KIND_XIF  = 2;

  logic                  clk;
  logic                  rst_n;
  logic                  ex_valid_i;
  logic                  ex_ready_o;
  logic                  ex_rf_we_i;
  wb_pkg::rf_addr_t      ex_rf_waddr_i;
  logic [`WB_XLEN-1:0]   ex_rf_wdata_i;
  logic                  ex_lsu_en_i;
  logic                  ex_xif_en_i;
  logic                  ex_abort_op_i;
  logic                  ex_last_op_i;
  logic                  halt_wb_i;
  logic                  halt_limited_wb_i;
  logic                  kill_wb_i;
  logic [`WB_XLEN-1:0]   lsu_rdata_i;
  logic                  lsu_rvalid_i;
  wb_pkg::mpu_status_e   lsu_mpu_status_i;
  wb_pkg::align_status_e lsu_align_status_i;
  logic                  lsu_wpt_match_i;
  logic                  lsu_ready_i;
  logic                  lsu_valid_o;
  logic                  xif_result_valid_i;
  logic [`WB_XLEN-1:0]   xif_result_data_i;
  logic                  xif_result_exc_i;
  logic                  xif_result_ready_o;
  wb_pkg::rf_addr_t      rf_raddr_i;
  logic [`WB_XLEN-1:0]   rf_rdata_o;
  logic                  wb_valid_o;
  logic                  data_stall_o;
  logic                  last_op_o;
  logic                  abort_op_o;
  wb_pkg::mpu_status_e   mpu_status_wb_o;
  wb_pkg::align_status_e align_status_wb_o;
  logic                  wpt_match_wb_o;

  integer                seed;
  int                    retired_count;
  int                    killed_count;

  // Expected register file contents, updated at each retirement
  logic [`WB_XLEN-1:0]   shadow_regs [`WB_NUM_REGS];

  wb_subsys u_wb_subsys (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_valid_i         (ex_valid_i),
    .ex_ready_o         (ex_ready_o),
    .ex_rf_we_i         (ex_rf_we_i),
    .ex_rf_waddr_i      (ex_rf_waddr_i),
    .ex_rf_wdata_i      (ex_rf_wdata_i),
    .ex_lsu_en_i        (ex_lsu_en_i),
    .ex_xif_en_i        (ex_xif_en_i),
    .ex_abort_op_i      (ex_abort_op_i),
    .ex_last_op_i       (ex_last_op_i),
    .halt_wb_i          (halt_wb_i),
    .halt_limited_wb_i  (halt_limited_wb_i),
    .kill_wb_i          (kill_wb_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .lsu_rvalid_i       (lsu_rvalid_i),
    .lsu_mpu_status_i   (lsu_mpu_status_i),
    .lsu_align_status_i (lsu_align_status_i),
    .lsu_wpt_match_i    (lsu_wpt_match_i),
    .lsu_ready_i        (lsu_ready_i),
    .lsu_valid_o        (lsu_valid_o),
    .xif_result_valid_i (xif_result_valid_i),
    .xif_result_data_i  (xif_result_data_i),
    .xif_result_exc_i   (xif_result_exc_i),
    .xif_result_ready_o (xif_result_ready_o),
    .rf_raddr_i         (rf_raddr_i),
    .rf_rdata_o         (rf_rdata_o),
    .wb_valid_o         (wb_valid_o),
    .data_stall_o       (data_stall_o),
    .last_op_o          (last_op_o),
    .abort_op_o         (abort_op_o),
    .mpu_status_wb_o    (mpu_status_wb_o),
    .align_status_wb_o  (align_status_wb_o),
    .wpt_match_wb_o     (wpt_match_wb_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock and watchdog

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Budget covers every instruction at its worst case plus reset and readback
  initial begin
    #((NUM_INSTR * CYCLES_PER_INSTR + 4 * `WB_NUM_REGS) * CLK_PERIOD);
    $display("The run hung: the instruction sequence did not finish in time");
    $display("STATUS: FAIL");
    $fatal(1, "Watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic int unsigned rand_below(input int unsigned n);
    int unsigned r;
    r = $unsigned($random(seed));
    return r % n;
  endfunction

  function automatic logic [`WB_XLEN-1:0] rand_word();
    return $random(seed);
  endfunction

  task automatic check_value(input string name, input logic [`WB_XLEN-1:0] got,
                             input logic [`WB_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Quiet LSU, coprocessor and controller; data buses carry junk on purpose
  task automatic drive_idle();
    ex_valid_i         = 1'b0;
    halt_wb_i          = 1'b0;
    halt_limited_wb_i  = 1'b0;
    kill_wb_i          = 1'b0;
    lsu_rdata_i        = rand_word();
    lsu_rvalid_i       = 1'b0;
    lsu_mpu_status_i   = wb_pkg::MPU_OK;
    lsu_align_status_i = wb_pkg::ALIGN_OK;
    lsu_wpt_match_i    = 1'b0;
    lsu_ready_i        = 1'b1;
    xif_result_valid_i = 1'b0;
    xif_result_data_i  = rand_word();
    xif_result_exc_i   = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One instruction from offer to register readback

  task automatic run_one_instr();
    int                    kind;
    int                    delay;
    int                    hold;
    logic                  do_kill;
    logic                  do_halt;
    logic                  fault;
    logic                  writes;
    logic                  rf_we;
    logic                  abort_in;
    logic                  last_in;
    wb_pkg::rf_addr_t      rd;
    wb_pkg::mpu_status_e   mpu;
    wb_pkg::align_status_e align;
    logic                  wpt;
    logic [`WB_XLEN-1:0]   result;

    kind     = rand_below(3);
    rd       = (rand_below(8) == 0) ? '0 : wb_pkg::rf_addr_t'(rand_below(`WB_NUM_REGS));
    rf_we    = (rand_below(8) != 0);
    abort_in = (rand_below(16) == 0);
    last_in  = rand_below(2);
    do_kill  = (rand_below(10) == 0);
    do_halt  = (rand_below(5) == 0);
    delay    = rand_below(5);
    writes   = 1'b0;

    // Offer the instruction and hold it until the pipe register has room
    @(negedge clk);
    drive_idle();
    ex_valid_i    = 1'b1;
    ex_rf_we_i    = rf_we;
    ex_rf_waddr_i = rd;
    ex_rf_wdata_i = rand_word();
    ex_lsu_en_i   = (kind == KIND_LOAD);
    ex_xif_en_i   = (kind == KIND_XIF);
    ex_abort_op_i = abort_in;
    ex_last_op_i  = last_in;
    result        = ex_rf_wdata_i;
    #10;
    while (!ex_ready_o) begin
      @(negedge clk);
      #10;
    end

    // First cycle with the instruction sitting in WB
    @(negedge clk);
    drive_idle();

    if (do_kill) begin
      // Kill frees the stage at once and nothing retires
      kill_wb_i = 1'b1;
      #10;
      check_value("wb_valid_o", wb_valid_o, 0);
      check_value("ex_ready_o", ex_ready_o, 1);
      killed_count++;
    end else begin
      case (kind)
        KIND_ALU: begin
          if (do_halt) begin
            hold = 1 + rand_below(3);
            repeat (hold) begin
              // Either halt source must block retirement
              if (rand_below(2) == 0) begin
                halt_wb_i = 1'b1;
              end else begin
                halt_limited_wb_i = 1'b1;
              end
              #10;
              check_value("wb_valid_o", wb_valid_o, 0);
              check_value("ex_ready_o", ex_ready_o, 0);
              @(negedge clk);
              drive_idle();
            end
          end
          #10;
          check_value("wb_valid_o", wb_valid_o, 1);
          check_value("data_stall_o", data_stall_o, 0);
          writes = rf_we;
        end
        KIND_LOAD: begin
          repeat (delay) begin
            #10;
            check_value("data_stall_o", data_stall_o, 1);
            check_value("lsu_valid_o", lsu_valid_o, 1);
            check_value("wb_valid_o", wb_valid_o, 0);
            check_value("ex_ready_o", ex_ready_o, 0);
            @(negedge clk);
            drive_idle();
          end
          case (rand_below(8))
            0:       mpu = wb_pkg::MPU_RE_FAULT;
            1:       mpu = wb_pkg::MPU_WR_FAULT;
            default: mpu = wb_pkg::MPU_OK;
          endcase
          align = (rand_below(8) == 0) ? wb_pkg::ALIGN_WR_ERR : wb_pkg::ALIGN_OK;
          wpt   = (rand_below(8) == 0);
          // Responses under halt only come with a fault since good loads never wait
          if (do_halt) begin
            wpt = 1'b1;
          end
          fault = (mpu != wb_pkg::MPU_OK) || (align != wb_pkg::ALIGN_OK) || wpt;
          lsu_rvalid_i       = 1'b1;
          lsu_mpu_status_i   = mpu;
          lsu_align_status_i = align;
          lsu_wpt_match_i    = wpt;
          result             = lsu_rdata_i;
          if (do_halt) begin
            halt_wb_i = 1'b1;
            #10;
            check_value("wb_valid_o", wb_valid_o, 0);
            hold = rand_below(3);
            repeat (hold) begin
              @(negedge clk);
              drive_idle();
              halt_wb_i = 1'b1;
              #10;
              check_value("wb_valid_o", wb_valid_o, 0);
            end
            // Live status is clean again, so only the held copy can show up
            @(negedge clk);
            drive_idle();
          end
          #10;
          check_value("wb_valid_o", wb_valid_o, 1);
          check_value("data_stall_o", data_stall_o, 0);
          check_value("mpu_status_wb_o", mpu_status_wb_o, mpu);
          check_value("align_status_wb_o", align_status_wb_o, align);
          check_value("wpt_match_wb_o", wpt_match_wb_o, wpt);
          abort_in = abort_in | fault;
          writes   = rf_we && !fault;
        end
        default: begin
          repeat (delay) begin
            #10;
            check_value("xif_result_ready_o", xif_result_ready_o, 1);
            check_value("wb_valid_o", wb_valid_o, 0);
            check_value("ex_ready_o", ex_ready_o, 0);
            @(negedge clk);
            drive_idle();
          end
          xif_result_valid_i = 1'b1;
          xif_result_exc_i   = (rand_below(4) == 0);
          result             = xif_result_data_i;
          #10;
          check_value("xif_result_ready_o", xif_result_ready_o, 1);
          check_value("wb_valid_o", wb_valid_o, 1);
          writes = rf_we && !xif_result_exc_i;
        end
      endcase
      check_value("abort_op_o", abort_op_o, abort_in);
      check_value("last_op_o", last_op_o, last_in);
      // x0 is hard-wired, so the model never changes it
      if (writes && (rd != '0)) begin
        shadow_regs[rd] = result;
      end
      retired_count++;
    end

    // Stage is empty again and the destination shows the expected value
    @(negedge clk);
    drive_idle();
    rf_raddr_i = rd;
    #10;
    check_value("wb_valid_o", wb_valid_o, 0);
    check_value("lsu_valid_o", lsu_valid_o, 0);
    check_value($sformatf("rf_rdata_o[x%0d]", rd), rf_rdata_o, shadow_regs[rd]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    seed          = 32'h62d3_252e;
    retired_count = 0;
    killed_count  = 0;
    for (int i = 0; i < `WB_NUM_REGS; i++) begin
      shadow_regs[i] = '0;
    end
    rst_n         = 1'b0;
    ex_rf_we_i    = 1'b0;
    ex_rf_waddr_i = '0;
    ex_rf_wdata_i = '0;
    ex_lsu_en_i   = 1'b0;
    ex_xif_en_i   = 1'b0;
    ex_abort_op_i = 1'b0;
    ex_last_op_i  = 1'b0;
    rf_raddr_i    = '0;
    drive_idle();

    // Outputs must be quiet while reset is held
    repeat (RESET_CYCLES - 1) @(negedge clk);
    #10;
    check_value("wb_valid_o", wb_valid_o, 0);
    check_value("lsu_valid_o", lsu_valid_o, 0);
    check_value("xif_result_ready_o", xif_result_ready_o, 0);
    check_value("data_stall_o", data_stall_o, 0);
    check_value("abort_op_o", abort_op_o, 0);
    check_value("ex_ready_o", ex_ready_o, 0);
    @(negedge clk);
    rst_n = 1'b1;
    #10;
    check_value("ex_ready_o", ex_ready_o, 0);
    @(negedge clk);
    #10;
    check_value("ex_ready_o", ex_ready_o, 1);

    for (int n = 0; n < NUM_INSTR; n++) begin
      run_one_instr();
    end

    // Final sweep catches stray writes to registers not just used
    for (int r = 0; r < `WB_NUM_REGS; r++) begin
      @(negedge clk);
      rf_raddr_i = wb_pkg::rf_addr_t'(r);
      #10;
      check_value($sformatf("rf_rdata_o[x%0d]", r), rf_rdata_o, shadow_regs[r]);
    end

    $display("Retired %0d instructions, killed %0d", retired_count, killed_count);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- src.f
+incdir+include
logic/wb_pkg.sv
logic/ex_wb_if.sv
logic/xif_result_if.sv
logic/ex_wb_pipe_reg.sv
logic/wb_stage.sv
logic/wb_regfile.sv
logic/wb_subsys.sv
test/tb_wb_subsys.sv

//--- Bender.yml
package:
  name: wb_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/wb_pkg.sv
      - logic/ex_wb_if.sv
      - logic/xif_result_if.sv
      - logic/ex_wb_pipe_reg.sv
      - logic/wb_stage.sv
      - logic/wb_regfile.sv
      - logic/wb_subsys.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_wb_subsys.sv
